// ==== logic/rob_pkg.sv ====
// sizes shared by the reorder buffer RTL and its testbench, imported where needed
package rob_pkg;

	// buffer geometry
	localparam int rob_depth = 8;
	localparam int rob_index_width = 3; // tag and pointer bits
	localparam int rob_count_width = 4; // occupancy runs 0 to rob_depth

	localparam int pc_width = 64;

	// destination register numbers
	localparam int arch_reg_width = 5;
	localparam int phys_reg_width = 6; // 64-entry physical register file

endpackage

// ==== logic/rob_pointers.sv ====
// head, tail and occupancy of the reorder buffer; decides dispatch acceptance and hands out tags
`timescale 1ns/100ps

module rob_pointers
(
	input logic clock,
	input logic reset,
	input logic inst1_load,
	input logic inst2_load,
	input logic [1:0] commit_count, // entries leaving at the head this cycle
	input logic flush,
	output logic [rob_pkg::rob_index_width-1:0] head,
	output logic [rob_pkg::rob_index_width-1:0] tail,
	output logic full,
	output logic [rob_pkg::rob_index_width-1:0] inst1_tag,
	output logic [rob_pkg::rob_index_width-1:0] inst2_tag,
	output logic inst1_write,
	output logic inst2_write,
	output logic [1:0] dispatch_count
);
	import rob_pkg::*;

	logic [rob_count_width-1:0] count;
	logic [rob_index_width-1:0] next_head;

	// full as soon as fewer than two slots are free
	assign full = count >= rob_count_width'(rob_depth - 1);

	// a committing mispredict kills this cycle's dispatch
	assign inst1_write = inst1_load && !full && !flush;
	assign inst2_write = inst1_write && inst2_load;
	assign dispatch_count = {1'b0, inst1_write} + {1'b0, inst2_write};

	assign inst1_tag = tail;
	assign inst2_tag = tail + 1'b1; // wraps with the pointer
	assign next_head = head + rob_index_width'(commit_count);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= next_head;
			if (flush)
			begin
				// everything younger than the branch is gone
				tail <= next_head;
				count <= '0;
			end
			else
			begin
				tail <= tail + rob_index_width'(dispatch_count);
				count <= count + rob_count_width'(dispatch_count)
					- rob_count_width'(commit_count);
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) count <= rob_count_width'(rob_depth))
	else $error("occupancy %0d above depth", count);

	// commit never takes more entries than the buffer holds
	assert property (@(posedge clock) disable iff (reset)
		rob_count_width'(commit_count) <= count)
	else $error("commit of %0d entries with occupancy %0d", commit_count, count);

endmodule

// ==== logic/rob_entries.sv ====
// storage of the eight reorder buffer entries, written by dispatch, completion and commit
`timescale 1ns/100ps

module rob_entries
(
	input logic clock,
	input logic reset,
	input logic [rob_pkg::rob_index_width-1:0] tail,
	input logic inst1_write,
	input logic inst2_write,
	input logic [rob_pkg::pc_width-1:0] inst1_pc,
	input logic [rob_pkg::arch_reg_width-1:0] inst1_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] inst1_phys_dest,
	input logic inst1_is_branch,
	input logic [rob_pkg::pc_width-1:0] inst2_pc,
	input logic [rob_pkg::arch_reg_width-1:0] inst2_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] inst2_phys_dest,
	input logic inst2_is_branch,
	input logic fu1_done,
	input logic [rob_pkg::rob_index_width-1:0] fu1_tag,
	input logic fu1_mispredict,
	input logic [rob_pkg::pc_width-1:0] fu1_target_pc,
	input logic fu2_done,
	input logic [rob_pkg::rob_index_width-1:0] fu2_tag,
	input logic fu2_mispredict,
	input logic [rob_pkg::pc_width-1:0] fu2_target_pc,
	input logic [rob_pkg::rob_index_width-1:0] head,
	input logic [1:0] commit_count,
	input logic flush,
	output logic head_valid,
	output logic head_done,
	output logic [rob_pkg::pc_width-1:0] head_pc,
	output logic [rob_pkg::pc_width-1:0] head_target_pc,
	output logic head_is_branch,
	output logic head_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] head_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] head_phys_dest,
	output logic next_valid,
	output logic next_done,
	output logic [rob_pkg::pc_width-1:0] next_pc,
	output logic [rob_pkg::pc_width-1:0] next_target_pc,
	output logic next_is_branch,
	output logic next_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] next_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] next_phys_dest
);
	import rob_pkg::*;

	logic [rob_depth-1:0] valid;
	logic [rob_depth-1:0] done;
	logic [rob_depth-1:0] mispredict;
	logic [rob_depth-1:0] is_branch;
	logic [pc_width-1:0] pc [rob_depth];
	logic [pc_width-1:0] target_pc [rob_depth];
	logic [arch_reg_width-1:0] arch_dest [rob_depth];
	logic [phys_reg_width-1:0] phys_dest [rob_depth];

	logic [rob_index_width-1:0] head_plus_one;
	logic [rob_index_width-1:0] tail_plus_one;
	logic [rob_depth-1:0] write1, write2, retire, fu1_hit, fu2_hit;

	assign head_plus_one = head + 1'b1;
	assign tail_plus_one = tail + 1'b1;

	// per-entry strobes
	always_comb
	begin
		for (int i = 0; i < rob_depth; i++)
		begin
			write1[i] = inst1_write && tail == rob_index_width'(i);
			write2[i] = inst2_write && tail_plus_one == rob_index_width'(i);
			retire[i] = (commit_count != 2'd0 && head == rob_index_width'(i))
				|| (commit_count == 2'd2 && head_plus_one == rob_index_width'(i));
			fu1_hit[i] = fu1_done && fu1_tag == rob_index_width'(i) && valid[i]; // stale tags dropped
			fu2_hit[i] = fu2_done && fu2_tag == rob_index_width'(i) && valid[i];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid <= '0;
			done <= '0;
		end
		else
		begin
			for (int i = 0; i < rob_depth; i++)
			begin
				if (flush)
					valid[i] <= 1'b0;
				else if (write1[i] || write2[i])
					valid[i] <= 1'b1;
				else if (retire[i])
					valid[i] <= 1'b0;

				if (write1[i] || write2[i])
					done[i] <= 1'b0;
				else if (fu1_hit[i] || fu2_hit[i])
					done[i] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int i = 0; i < rob_depth; i++)
		begin
			if (write1[i])
			begin
				pc[i] <= inst1_pc;
				arch_dest[i] <= inst1_arch_dest;
				phys_dest[i] <= inst1_phys_dest;
				is_branch[i] <= inst1_is_branch;
				mispredict[i] <= 1'b0;
			end
			else if (write2[i])
			begin
				pc[i] <= inst2_pc;
				arch_dest[i] <= inst2_arch_dest;
				phys_dest[i] <= inst2_phys_dest;
				is_branch[i] <= inst2_is_branch;
				mispredict[i] <= 1'b0;
			end
			else if (fu1_hit[i])
			begin
				mispredict[i] <= fu1_mispredict;
				target_pc[i] <= fu1_target_pc;
			end
			else if (fu2_hit[i])
			begin
				mispredict[i] <= fu2_mispredict;
				target_pc[i] <= fu2_target_pc;
			end
		end
	end

	// the two oldest entries go to commit select
	assign head_valid = valid[head];
	assign head_done = done[head];
	assign head_pc = pc[head];
	assign head_target_pc = target_pc[head];
	assign head_is_branch = is_branch[head];
	assign head_mispredict = mispredict[head];
	assign head_arch_dest = arch_dest[head];
	assign head_phys_dest = phys_dest[head];
	assign next_valid = valid[head_plus_one];
	assign next_done = done[head_plus_one];
	assign next_pc = pc[head_plus_one];
	assign next_target_pc = target_pc[head_plus_one];
	assign next_is_branch = is_branch[head_plus_one];
	assign next_mispredict = mispredict[head_plus_one];
	assign next_arch_dest = arch_dest[head_plus_one];
	assign next_phys_dest = phys_dest[head_plus_one];

	// the units never finish the same instruction in one cycle
	assert property (@(posedge clock) disable iff (reset)
		fu1_done && fu2_done |-> fu1_tag != fu2_tag)
	else $error("both units reported tag %0d", fu1_tag);

endmodule

// ==== logic/rob_commit_select.sv ====
// picks the committing entries at the head of the reorder buffer and raises the flush for the top level
`timescale 1ns/100ps

module rob_commit_select
(
	input logic head_valid,
	input logic head_done,
	input logic [rob_pkg::pc_width-1:0] head_pc,
	input logic [rob_pkg::pc_width-1:0] head_target_pc,
	input logic head_is_branch,
	input logic head_mispredict,
	input logic [rob_pkg::arch_reg_width-1:0] head_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] head_phys_dest,
	input logic next_valid,
	input logic next_done,
	input logic [rob_pkg::pc_width-1:0] next_pc,
	input logic [rob_pkg::pc_width-1:0] next_target_pc,
	input logic next_is_branch,
	input logic next_mispredict,
	input logic [rob_pkg::arch_reg_width-1:0] next_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] next_phys_dest,
	output logic [1:0] commit_count,
	output logic flush,
	output logic commit1_valid,
	output logic [rob_pkg::pc_width-1:0] commit1_pc,
	output logic [rob_pkg::pc_width-1:0] commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] commit1_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] commit1_phys_dest,
	output logic commit2_valid,
	output logic [rob_pkg::pc_width-1:0] commit2_pc,
	output logic [rob_pkg::pc_width-1:0] commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] commit2_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] commit2_phys_dest
);
	import rob_pkg::*;

	always_comb
	begin
		commit1_valid = head_valid && head_done;
		commit1_mispredict = commit1_valid && head_is_branch && head_mispredict;
		// nothing behind a redirecting branch may retire
		commit2_valid = commit1_valid && !commit1_mispredict && next_valid && next_done;
		commit2_mispredict = commit2_valid && next_is_branch && next_mispredict;

		flush = commit1_mispredict || commit2_mispredict;
		commit_count = commit2_valid ? 2'd2 : {1'b0, commit1_valid};

		// slot payloads are zero when the slot is idle
		commit1_pc = commit1_valid ? head_pc : '0;
		commit1_target_pc = commit1_valid ? head_target_pc : '0;
		commit1_is_branch = commit1_valid && head_is_branch;
		commit1_arch_dest = commit1_valid ? head_arch_dest : '0;
		commit1_phys_dest = commit1_valid ? head_phys_dest : '0;

		commit2_pc = commit2_valid ? next_pc : '0;
		commit2_target_pc = commit2_valid ? next_target_pc : '0;
		commit2_is_branch = commit2_valid && next_is_branch;
		commit2_arch_dest = commit2_valid ? next_arch_dest : '0;
		commit2_phys_dest = commit2_valid ? next_phys_dest : '0;

		// the entry behind the head is only ever valid with the head itself valid
		assert (!next_valid || head_valid)
		else $error("entry behind the head valid while the head is empty");
	end

endmodule

// ==== logic/rob.sv ====
// reorder buffer top level for one thread, two-wide dispatch, completion and commit
`timescale 1ns/100ps

module rob
(
	input logic clock,
	input logic reset,
	input logic inst1_load,
	input logic [rob_pkg::pc_width-1:0] inst1_pc,
	input logic [rob_pkg::arch_reg_width-1:0] inst1_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] inst1_phys_dest,
	input logic inst1_is_branch,
	input logic inst2_load, // only together with inst1_load
	input logic [rob_pkg::pc_width-1:0] inst2_pc,
	input logic [rob_pkg::arch_reg_width-1:0] inst2_arch_dest,
	input logic [rob_pkg::phys_reg_width-1:0] inst2_phys_dest,
	input logic inst2_is_branch,
	input logic fu1_done,
	input logic [rob_pkg::rob_index_width-1:0] fu1_tag,
	input logic fu1_mispredict,
	input logic [rob_pkg::pc_width-1:0] fu1_target_pc,
	input logic fu2_done,
	input logic [rob_pkg::rob_index_width-1:0] fu2_tag,
	input logic fu2_mispredict,
	input logic [rob_pkg::pc_width-1:0] fu2_target_pc,
	output logic full,
	output logic [rob_pkg::rob_index_width-1:0] inst1_tag,
	output logic [rob_pkg::rob_index_width-1:0] inst2_tag,
	output logic commit1_valid,
	output logic [rob_pkg::pc_width-1:0] commit1_pc,
	output logic [rob_pkg::pc_width-1:0] commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] commit1_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] commit1_phys_dest,
	output logic commit2_valid,
	output logic [rob_pkg::pc_width-1:0] commit2_pc,
	output logic [rob_pkg::pc_width-1:0] commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output logic [rob_pkg::arch_reg_width-1:0] commit2_arch_dest,
	output logic [rob_pkg::phys_reg_width-1:0] commit2_phys_dest
);
	import rob_pkg::*;

	// pointer block outputs
	logic [rob_index_width-1:0] head;
	logic [rob_index_width-1:0] tail;
	logic inst1_write;
	logic inst2_write;

	// commit decision back to the pointers and entries
	logic [1:0] commit_count;
	logic flush;

	// the two oldest entries
	logic head_valid, head_done, head_is_branch, head_mispredict;
	logic [pc_width-1:0] head_pc;
	logic [pc_width-1:0] head_target_pc;
	logic [arch_reg_width-1:0] head_arch_dest;
	logic [phys_reg_width-1:0] head_phys_dest;
	logic next_valid, next_done, next_is_branch, next_mispredict;
	logic [pc_width-1:0] next_pc;
	logic [pc_width-1:0] next_target_pc;
	logic [arch_reg_width-1:0] next_arch_dest;
	logic [phys_reg_width-1:0] next_phys_dest;

	// ports connect by name and the dispatch count stays inside the pointers
	rob_pointers u_pointers (.dispatch_count(), .*);

	rob_entries u_entries (.*);

	rob_commit_select u_commit_select (.*);

endmodule

// ==== include/rob_tb_tasks.svh ====
// stimulus tasks and the reference queue model, included in the body of the reorder buffer testbench
`ifndef ROB_TB_TASKS_SVH
`define ROB_TB_TASKS_SVH

localparam int model_entry_width = rob_pkg::pc_width + rob_pkg::arch_reg_width
	+ rob_pkg::phys_reg_width + 1;

// accepted dispatches, oldest first: {pc, arch_dest, phys_dest, is_branch}
logic [model_entry_width-1:0] model_queue [$];
logic [rob_pkg::rob_index_width-1:0] model_tail;

// records whatever dispatch is on the inputs right now
function automatic void model_accept();
	model_queue.push_back({inst1_pc, inst1_arch_dest, inst1_phys_dest, inst1_is_branch});
	model_tail = model_tail + 1'b1;
	if (inst2_load)
	begin
		model_queue.push_back({inst2_pc, inst2_arch_dest, inst2_phys_dest, inst2_is_branch});
		model_tail = model_tail + 1'b1;
	end
endfunction

task automatic idle_cycle();
	@(posedge clock);
	#2;
	inst1_load = 1'b0;
	inst2_load = 1'b0;
	fu1_done = 1'b0;
	fu2_done = 1'b0;
endtask

task automatic dispatch(input bit both, input bit branch1, input bit branch2);
	@(posedge clock);
	#2;
	fu1_done = 1'b0;
	fu2_done = 1'b0;
	inst1_load = 1'b1;
	inst1_pc = {$urandom(), $urandom() & 32'hffff_fffc}; // word aligned
	inst1_arch_dest = rob_pkg::arch_reg_width'($urandom());
	inst1_phys_dest = rob_pkg::phys_reg_width'($urandom());
	inst1_is_branch = branch1;
	inst2_load = both;
	inst2_pc = inst1_pc + 64'd4;
	inst2_arch_dest = rob_pkg::arch_reg_width'($urandom());
	inst2_phys_dest = rob_pkg::phys_reg_width'($urandom());
	inst2_is_branch = branch2;
endtask

task automatic report_done(input bit done1, input logic [rob_pkg::rob_index_width-1:0] tag1,
	input bit mispredict1, input bit done2, input logic [rob_pkg::rob_index_width-1:0] tag2,
	input bit mispredict2);
	@(posedge clock);
	#2;
	inst1_load = 1'b0;
	inst2_load = 1'b0;
	fu1_done = done1;
	fu1_tag = tag1;
	fu1_mispredict = mispredict1;
	fu1_target_pc = {$urandom(), $urandom() & 32'hffff_fffc};
	fu2_done = done2;
	fu2_tag = tag2;
	fu2_mispredict = mispredict2;
	fu2_target_pc = {$urandom(), $urandom() & 32'hffff_fffc};
endtask

`endif

// ==== verif/tb_rob.sv ====
// testbench top for the reorder buffer that checks tags, commit order, flush and full against a queue model
`timescale 1ns/100ps

module tb_rob;
	import rob_pkg::*;

	localparam int seed = 91;
	localparam int random_rounds = 300;
	localparam int test_cycles = 500; // random rounds, drains and directed tests together
	localparam int cycle_limit = 4 * test_cycles;

	logic clock;
	logic reset;
	logic inst1_load, inst2_load;
	logic [pc_width-1:0] inst1_pc, inst2_pc;
	logic [arch_reg_width-1:0] inst1_arch_dest, inst2_arch_dest;
	logic [phys_reg_width-1:0] inst1_phys_dest, inst2_phys_dest;
	logic inst1_is_branch, inst2_is_branch;
	logic fu1_done, fu2_done;
	logic [rob_index_width-1:0] fu1_tag, fu2_tag;
	logic fu1_mispredict, fu2_mispredict;
	logic [pc_width-1:0] fu1_target_pc, fu2_target_pc;
	logic full;
	logic [rob_index_width-1:0] inst1_tag, inst2_tag;
	logic commit1_valid, commit1_is_branch, commit1_mispredict;
	logic [pc_width-1:0] commit1_pc, commit1_target_pc;
	logic [arch_reg_width-1:0] commit1_arch_dest;
	logic [phys_reg_width-1:0] commit1_phys_dest;
	logic commit2_valid, commit2_is_branch, commit2_mispredict;
	logic [pc_width-1:0] commit2_pc, commit2_target_pc;
	logic [arch_reg_width-1:0] commit2_arch_dest;
	logic [phys_reg_width-1:0] commit2_phys_dest;

	`include "rob_tb_tasks.svh"

	// model state beside the queue from the header
	logic [rob_index_width-1:0] model_head;
	logic [rob_depth-1:0] model_done;
	logic [rob_depth-1:0] model_mispredict;
	logic [pc_width-1:0] model_target [rob_depth];
	logic [rob_index_width-1:0] pending [$]; // accepted tags not yet reported

	// expected outputs for the cycle before the next edge
	logic exp_commit1, exp_commit2, exp_mispredict1, exp_mispredict2, exp_full, exp_flush;
	logic [model_entry_width-1:0] exp_entry1, exp_entry2;
	logic [pc_width-1:0] exp_target1, exp_target2;
	logic [rob_index_width-1:0] exp_tag;

	string test_name;
	int tag_errors = 0;
	int commit_errors = 0;
	int full_errors = 0;
	int reset_errors = 0;
	int cycle_count = 0;

	assign exp_flush = exp_mispredict1 || exp_mispredict2;

	rob DUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// a report only lands on an entry that is in the model
	function automatic void record_completion(input logic [rob_index_width-1:0] tag,
		input logic mispredict, input logic [pc_width-1:0] target);
		logic [rob_index_width-1:0] offset;
		offset = tag - model_head;
		if (offset < model_queue.size())
		begin
			model_done[tag] = 1'b1;
			model_mispredict[tag] = mispredict;
			model_target[tag] = target;
		end
	endfunction

	always @(posedge clock)
	begin
		logic [rob_index_width-1:0] second;
		logic [model_entry_width-1:0] entry1, entry2;
		bit c1, c2, m1, m2;
		int size;
		if (reset)
		begin
			model_queue.delete();
			pending.delete();
			model_head = '0;
			model_tail = '0;
			model_done = '0;
			model_mispredict = '0;
		end
		else
		begin
			if (fu1_done)
				record_completion(fu1_tag, fu1_mispredict, fu1_target_pc);
			if (fu2_done)
				record_completion(fu2_tag, fu2_mispredict, fu2_target_pc);
			if (exp_commit1)
			begin
				void'(model_queue.pop_front());
				model_head = model_head + 1'b1;
			end
			if (exp_commit2)
			begin
				void'(model_queue.pop_front());
				model_head = model_head + 1'b1;
			end
			if (exp_flush)
			begin
				// younger entries vanish and the tail restarts behind the branch
				model_queue.delete();
				pending.delete();
				model_tail = model_head;
			end
			else if (inst1_load && !exp_full)
			begin
				second = model_tail + 1'b1;
				model_done[model_tail] = 1'b0;
				model_mispredict[model_tail] = 1'b0;
				pending.push_back(model_tail);
				if (inst2_load)
				begin
					model_done[second] = 1'b0;
					model_mispredict[second] = 1'b0;
					pending.push_back(second);
				end
				model_accept();
			end
		end

		size = model_queue.size();
		second = model_head + 1'b1;
		entry1 = size >= 1 ? model_queue[0] : '0;
		entry2 = size >= 2 ? model_queue[1] : '0;
		c1 = size >= 1 && model_done[model_head];
		m1 = c1 && entry1[0] && model_mispredict[model_head]; // lowest bit is is_branch
		c2 = c1 && !m1 && size >= 2 && model_done[second];
		m2 = c2 && entry2[0] && model_mispredict[second];
		exp_commit1 <= c1;
		exp_commit2 <= c2;
		exp_mispredict1 <= m1;
		exp_mispredict2 <= m2;
		exp_entry1 <= c1 ? entry1 : '0;
		exp_entry2 <= c2 ? entry2 : '0;
		exp_target1 <= c1 ? model_target[model_head] : '0;
		exp_target2 <= c2 ? model_target[second] : '0;
		exp_full <= size >= rob_depth - 1;
		exp_tag <= model_tail;
	end

	assert property (@(posedge clock) disable iff (reset)
		inst1_load && !exp_full && !exp_flush
		|-> inst1_tag == exp_tag && inst2_tag == exp_tag + 1'b1)
	else
	begin
		tag_errors++;
		$display("Error %s: tags expected %0d %0d, actual %0d %0d", test_name,
			$sampled(exp_tag), $sampled(exp_tag + 1'b1), $sampled(inst1_tag),
			$sampled(inst2_tag));
	end

	assert property (@(posedge clock) disable iff (reset)
		commit1_valid == exp_commit1 && commit2_valid == exp_commit2)
	else
	begin
		commit_errors++;
		$display("Error %s: commit valids expected %b%b, actual %b%b", test_name,
			$sampled(exp_commit1), $sampled(exp_commit2), $sampled(commit1_valid),
			$sampled(commit2_valid));
	end

	assert property (@(posedge clock) disable iff (reset) exp_commit1
		|-> {commit1_pc, commit1_arch_dest, commit1_phys_dest, commit1_is_branch,
			commit1_mispredict, commit1_target_pc} == {exp_entry1, exp_mispredict1, exp_target1})
	else
	begin
		commit_errors++;
		$display("Error %s: slot 1 expected %h, actual %h", test_name,
			$sampled({exp_entry1, exp_mispredict1, exp_target1}),
			$sampled({commit1_pc, commit1_arch_dest, commit1_phys_dest, commit1_is_branch,
				commit1_mispredict, commit1_target_pc}));
	end

	assert property (@(posedge clock) disable iff (reset) exp_commit2
		|-> {commit2_pc, commit2_arch_dest, commit2_phys_dest, commit2_is_branch,
			commit2_mispredict, commit2_target_pc} == {exp_entry2, exp_mispredict2, exp_target2})
	else
	begin
		commit_errors++;
		$display("Error %s: slot 2 expected %h, actual %h", test_name,
			$sampled({exp_entry2, exp_mispredict2, exp_target2}),
			$sampled({commit2_pc, commit2_arch_dest, commit2_phys_dest, commit2_is_branch,
				commit2_mispredict, commit2_target_pc}));
	end

	assert property (@(posedge clock) disable iff (reset) full == exp_full)
	else
	begin
		full_errors++;
		$display("Error %s: full expected %b, actual %b", test_name, $sampled(exp_full),
			$sampled(full));
	end

	// registers hold their reset value from the second reset edge on
	assert property (@(posedge clock) reset && $past(reset)
		|-> !commit1_valid && !commit2_valid && !full)
	else
	begin
		reset_errors++;
		$display("Error %s: commit1/commit2/full expected 000, actual %b%b%b", test_name,
			$sampled(commit1_valid), $sampled(commit2_valid), $sampled(full));
	end

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	// reports one or two outstanding instructions in random order
	task automatic complete_some();
		int i;
		int j;
		logic [rob_index_width-1:0] tag1;
		logic [rob_index_width-1:0] tag2;
		if (pending.size() == 0)
		begin
			idle_cycle();
			return;
		end
		i = $urandom % pending.size();
		tag1 = pending[i];
		pending.delete(i);
		if (pending.size() > 0 && $urandom % 2 == 1)
		begin
			j = $urandom % pending.size();
			tag2 = pending[j];
			pending.delete(j);
			report_done(1'b1, tag1, 1'b0, 1'b1, tag2, 1'b0);
		end
		else
			report_done(1'b1, tag1, 1'b0, 1'b0, '0, 1'b0);
	endtask

	task automatic drain();
		idle_cycle(); // lets a dispatch still on the inputs land first
		while (pending.size() > 0)
			complete_some();
		while (model_queue.size() > 0)
			idle_cycle();
	endtask

	initial
	begin
		void'($urandom(seed));
		test_name = "reset";
		reset = 1'b1;
		inst1_load = 1'b0;
		inst1_pc = '0;
		inst1_arch_dest = '0;
		inst1_phys_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_load = 1'b0;
		inst2_pc = '0;
		inst2_arch_dest = '0;
		inst2_phys_dest = '0;
		inst2_is_branch = 1'b0;
		fu1_done = 1'b0;
		fu1_tag = '0;
		fu1_mispredict = 1'b0;
		fu1_target_pc = '0;
		fu2_done = 1'b0;
		fu2_tag = '0;
		fu2_mispredict = 1'b0;
		fu2_target_pc = '0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;
		idle_cycle();

		test_name = "random_commit";
		for (int round = 0; round < random_rounds; round++)
		begin
			if ($urandom % 2 == 1)
				dispatch(1'($urandom), 1'($urandom), 1'($urandom));
			else
				complete_some();
		end
		drain();

		test_name = "dual_commit";
		dispatch(1'b1, 1'b0, 1'b0);
		idle_cycle();
		report_done(1'b1, pending[0], 1'b0, 1'b1, pending[1], 1'b0); // both done at one edge
		pending.delete();
		drain();

		test_name = "mispredict_flush";
		dispatch(1'b1, 1'b1, 1'b0); // branch leads the pair
		dispatch(1'b1, 1'b0, 1'b0);
		idle_cycle();
		report_done(1'b1, pending[1], 1'b0, 1'b1, pending[2], 1'b0);
		report_done(1'b1, pending[3], 1'b0, 1'b1, pending[0], 1'b1);
		pending.delete();
		idle_cycle();
		idle_cycle();
		dispatch(1'b0, 1'b0, 1'b0); // takes the tag behind the branch
		drain();

		test_name = "full";
		repeat (rob_depth - 1) dispatch(1'b0, 1'b0, 1'b0);
		dispatch(1'b0, 1'b0, 1'b0); // arrives while full
		idle_cycle();
		drain();

		$display("errors: tag %0d, commit %0d, full %0d, reset %0d", tag_errors, commit_errors,
			full_errors, reset_errors);
		if (tag_errors + commit_errors + full_errors + reset_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
logic/rob_pkg.sv
logic/rob_pointers.sv
logic/rob_entries.sv
logic/rob_commit_select.sv
logic/rob.sv
verif/tb_rob.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the reorder buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rob -f vlog.f -o tb_rob_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_rob_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
